//--- hdl/acqSequencer.sv
`timescale 1ns/10ps
`include "histogram_settings.svh"

module acqSequencer (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   enable,
    input  logic [`COUNT_BITS-1:0] frameLen,
    input  logic                   statusRead,
    output logic                   swap,
    output logic                   activeBank,
    output logic                   frameReady,
    output logic [15:0]            frameNum
);
    import histPkg::*;

    binCount_t cycleCnt;
    binCount_t lastCycle;
    logic      frameDone;

    // frameReady held off until the last old-bank write has landed
    logic [`DRAIN_CYCLES-2:0] drainDly;

    assign lastCycle = frameLen - 1'b1;  // frameLen is never 0
    assign frameDone = drainDly[`DRAIN_CYCLES-2];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cycleCnt   <= '0;
            swap       <= 1'b0;
            activeBank <= 1'b0;
        end else begin
            swap <= 1'b0;
            if (!enable) begin
                cycleCnt <= '0;                // restart the frame on re-enable
            end else if (cycleCnt == lastCycle) begin
                cycleCnt   <= '0;
                swap       <= 1'b1;
                activeBank <= !activeBank;
            end else begin
                cycleCnt <= cycleCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            drainDly <= '0;
        end else begin
            drainDly <= {drainDly[`DRAIN_CYCLES-3:0], swap};
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            frameReady <= 1'b0;
            frameNum   <= '0;
        end else begin
            if (statusRead) begin
                frameReady <= 1'b0;
            end
            // a finishing frame wins over a status read in the same cycle
            if (frameDone) begin
                frameReady <= 1'b1;
                frameNum   <= frameNum + 1'b1;
            end
        end
    end

endmodule

//--- hdl/binCounterRam.sv
`timescale 1ns/10ps
`include "histogram_settings.svh"

module binCounterRam (
    input  logic               clk,
    input  logic               res,
    input  logic               mapValid,
    input  histPkg::binAddr_t  mapBin,
    input  logic               mapBank,
    input  logic               swap,
    input  logic               activeBank,
    input  histPkg::binAddr_t  rdBin,
    output histPkg::binCount_t rdCount
);
    import histPkg::*;

    // count storage, one row per bank
    binCount_t mem [`NUM_BANKS][`NUM_BINS];

    // a clear valid bit means the stored count is stale
    logic [`NUM_BINS-1:0] valid [`NUM_BANKS];

    // read stage
    logic      s1Valid;
    logic      s1Bank;
    binAddr_t  s1Bin;
    binCount_t s1Count;
    logic      s1Hit;

    // write stage
    binCount_t wrCount;
    logic      forward;
    logic      inactiveBank;

    assign wrCount = s1Hit ? s1Count + 1'b1 : binCount_t'(1); // first hit starts at 1

    // back-to-back hits on one bin take the count being written
    assign forward = s1Valid && (s1Bank == mapBank) && (s1Bin == mapBin);

    assign inactiveBank = !activeBank;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= mapValid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bank <= mapBank;
        s1Bin  <= mapBin;
        if (forward) begin
            s1Count <= wrCount;
            s1Hit   <= 1'b1;
        end else begin
            s1Count <= mem[mapBank][mapBin];
            s1Hit   <= valid[mapBank][mapBin];
        end
    end

    always_ff @(posedge clk) begin
        if (s1Valid) begin
            mem[s1Bank][s1Bin] <= wrCount;
        end
    end

    // lazy clear of the bank that becomes active
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int b = 0; b < `NUM_BANKS; b++) begin
                valid[b] <= '0;
            end
        end else begin
            if (swap) begin
                valid[activeBank] <= '0;       // activeBank already points at the new bank
            end
            if (s1Valid) begin
                valid[s1Bank][s1Bin] <= 1'b1;
            end
        end
    end

    // host side, finished bank only
    always_ff @(posedge clk) begin
        if (valid[inactiveBank][rdBin]) begin
            rdCount <= mem[inactiveBank][rdBin];
        end else begin
            rdCount <= '0;
        end
    end

endmodule

//--- hdl/binMapper.sv
`timescale 1ns/10ps
`include "histogram_settings.svh"

module binMapper (
    input  logic                clk,
    input  logic                res,
    input  logic                enable,
    input  histPkg::histMode_t  mode,
    input  histPkg::timestamp_t winStart,
    input  logic                hitValid,
    input  histPkg::timestamp_t hitTime,
    input  logic                activeBank,
    output logic                mapValid,
    output histPkg::binAddr_t   mapBin,
    output logic                mapBank
);
    import histPkg::*;

    timestamp_t coarseShifted;
    timestamp_t fineOffset;
    timestamp_t fineShifted;
    logic       belowWindow;
    logic       beyondWindow;
    logic       binOk;
    binAddr_t   bin;

    assign coarseShifted = hitTime >> `COARSE_SHIFT;
    assign fineOffset    = hitTime - winStart;     // wraps below window, masked below
    assign fineShifted   = fineOffset >> `FINE_SHIFT;
    assign belowWindow   = hitTime < winStart;
    assign beyondWindow  = (fineShifted >> `NB_BITS) != '0; // offset of 64 bins or more

    always_comb begin
        if (mode == FINE) begin
            bin   = fineShifted[`NB_BITS-1:0];
            binOk = !belowWindow && !beyondWindow;
        end else begin
            bin   = coarseShifted[`NB_BITS-1:0];
            binOk = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            mapValid <= 1'b0;
        end else begin
            mapValid <= enable && hitValid && binOk;
        end
    end

    // bank is taken at hit time so a hit in flight stays in its frame
    always_ff @(posedge clk) begin
        mapBin  <= bin;
        mapBank <= activeBank;
    end

endmodule

//--- hdl/histPkg.sv
`include "histogram_settings.svh"

package histPkg;

    // bin index into one bank
    typedef logic [`NB_BITS-1:0] binAddr_t;

    typedef logic [`COUNT_BITS-1:0] binCount_t;

    typedef logic [`TS_BITS-1:0] timestamp_t;

    // coarse spans all timestamps, fine spans a window from winStart
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } histMode_t;

    // register word addresses, bin space sits above with the top adr bit set
    typedef enum logic [1:0] {
        REG_CTRL     = 2'd0,
        REG_FRAMELEN = 2'd1,
        REG_WINSTART = 2'd2,
        REG_STATUS   = 2'd3
    } regIndex_t;

endpackage

//--- hdl/histTop.sv
`timescale 1ns/10ps
`include "histogram_settings.svh"

module histTop (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    hitValid,
    input  histPkg::timestamp_t     hitTime,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [`WB_ADR_BITS-1:0] adr,
    input  logic [`WB_DAT_BITS-1:0] datWr,
    output logic [`WB_DAT_BITS-1:0] datRd,
    output logic                    ack
);
    import histPkg::*;

    // mapper to RAM
    logic     mapValid;
    binAddr_t mapBin;
    logic     mapBank;

    // sequencer outputs
    logic        activeBank;
    logic        swap;
    logic        frameReady;
    logic [15:0] frameNum;

    // register file outputs
    logic                   enable;
    histMode_t              mode;
    logic [`COUNT_BITS-1:0] frameLen;
    timestamp_t             winStart;
    logic                   statusRead;
    binAddr_t               rdBin;
    binCount_t              rdCount;

    binMapper mapper (
        .clk(clk), .res(res), .enable(enable), .mode(mode), .winStart(winStart),
        .hitValid(hitValid), .hitTime(hitTime), .activeBank(activeBank),
        .mapValid(mapValid), .mapBin(mapBin), .mapBank(mapBank)
    );

    binCounterRam counter (
        .clk(clk), .res(res), .mapValid(mapValid), .mapBin(mapBin), .mapBank(mapBank),
        .swap(swap), .activeBank(activeBank), .rdBin(rdBin), .rdCount(rdCount)
    );

    acqSequencer sequencer (
        .clk(clk), .res(res), .enable(enable), .frameLen(frameLen),
        .statusRead(statusRead), .swap(swap), .activeBank(activeBank),
        .frameReady(frameReady), .frameNum(frameNum)
    );

    wbReadout host (
        .clk(clk), .res(res), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datWr(datWr), .datRd(datRd), .ack(ack), .enable(enable), .mode(mode),
        .frameLen(frameLen), .winStart(winStart), .statusRead(statusRead),
        .rdBin(rdBin), .rdCount(rdCount), .frameReady(frameReady), .frameNum(frameNum)
    );

endmodule

//--- hdl/histogram_settings.svh
`ifndef HISTOGRAM_SETTINGS_SVH
`define HISTOGRAM_SETTINGS_SVH

// histogram geometry
`define NB_BITS      6                    // bin address width
`define NUM_BINS     (1 << `NB_BITS)
`define NUM_BANKS    2                    // active + finished
`define COUNT_BITS   16

// detector side
`define TS_BITS      12                   // timestamp width

// timestamp to bin mapping
`define COARSE_SHIFT 6                    // full range into 64 bins
`define FINE_SHIFT   2                    // 4 ticks per bin inside the window

// frameReady waits for the RMW pipeline to empty
`define DRAIN_CYCLES 3

// host bus
`define WB_ADR_BITS  8                    // word addresses
`define WB_DAT_BITS  32

`endif

//--- hdl/wbReadout.sv
`timescale 1ns/10ps
`include "histogram_settings.svh"

module wbReadout (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [`WB_ADR_BITS-1:0] adr,
    input  logic [`WB_DAT_BITS-1:0] datWr,
    output logic [`WB_DAT_BITS-1:0] datRd,
    output logic                    ack,
    output logic                    enable,
    output histPkg::histMode_t      mode,
    output logic [`COUNT_BITS-1:0]  frameLen,
    output histPkg::timestamp_t     winStart,
    output logic                    statusRead,
    output histPkg::binAddr_t       rdBin,
    input  histPkg::binCount_t      rdCount,
    input  logic                    frameReady,
    input  logic [15:0]             frameNum
);
    import histPkg::*;

    logic                    reqStart;
    logic                    reqPend;   // second cycle of an access
    logic                    isBin;
    logic                    isReg;
    regIndex_t               regIdx;
    logic [`WB_DAT_BITS-1:0] readData;
    logic [`COUNT_BITS-1:0]  frameLenWr;

    // ignore the request while the previous one is still acking
    assign reqStart = cyc && stb && !reqPend && !ack;

    assign isBin  = adr[`WB_ADR_BITS-1];
    assign isReg  = !isBin && (adr[`WB_ADR_BITS-2:2] == '0);
    assign regIdx = regIndex_t'(adr[1:0]);
    assign rdBin  = adr[`NB_BITS-1:0];   // RAM registers the count during the first cycle

    assign frameLenWr = (datWr[`COUNT_BITS-1:0] == '0) ? `COUNT_BITS'(1)
                                                      : datWr[`COUNT_BITS-1:0];

    always_comb begin
        readData = '0;
        if (isBin) begin
            readData[`COUNT_BITS-1:0] = rdCount;
        end else if (isReg) begin
            case (regIdx)
                REG_CTRL:     readData[1:0] = {mode, enable};
                REG_FRAMELEN: readData[`COUNT_BITS-1:0] = frameLen;
                REG_WINSTART: readData[`TS_BITS-1:0] = winStart;
                REG_STATUS: begin
                    readData[31:16] = frameNum;
                    readData[0]     = frameReady;
                end
                default: readData = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            reqPend    <= 1'b0;
            ack        <= 1'b0;
            statusRead <= 1'b0;
            enable     <= 1'b0;
            mode       <= COARSE;
            frameLen   <= `COUNT_BITS'(1);
            winStart   <= '0;
        end else begin
            reqPend    <= reqStart;
            ack        <= reqPend;
            // clear lands on the edge that captures the status word
            statusRead <= reqStart && !we && isReg && (regIdx == REG_STATUS);
            if (reqPend && we && isReg) begin
                case (regIdx)
                    REG_CTRL: begin
                        enable <= datWr[0];
                        mode   <= histMode_t'(datWr[1]);
                    end
                    REG_FRAMELEN: frameLen <= frameLenWr;
                    REG_WINSTART: winStart <= datWr[`TS_BITS-1:0];
                    default: ;                 // status is read only
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reqPend) begin
            datRd <= readData;
        end
    end

endmodule

//--- project.f
+incdir+hdl
hdl/histPkg.sv
hdl/binMapper.sv
hdl/binCounterRam.sv
hdl/acqSequencer.sv
hdl/wbReadout.sv
hdl/histTop.sv
test/clockGen.sv
test/histTb.sv

//--- run.sh
#!/bin/sh
# compile and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module histTb -Mdir "$BUILD_DIR" -f project.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/VhistTb" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- test/clockGen.sv
`timescale 1ns/10ps

module clockGen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10,
    parameter int DRIVE_DELAY  = 10
) (
    output logic clk,
    output logic res
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

    // released just after an edge, like all other stimulus
    initial begin
        res = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        res = 1'b1;
    end

endmodule

//--- test/histTb.sv
`timescale 1ns/10ps
`include "histogram_settings.svh"

module histTb;
    import histPkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int ACK_TIMEOUT = 8;              // cycles

    // each frame is well longer than the hits driven into it
    localparam int FRAME1_LEN  = 400;
    localparam int FRAME2_LEN  = 400;
    localparam int FRAME3_LEN  = 200;
    localparam int FRAME4_LEN  = 200;
    localparam int RANDOM_HITS = 150;
    localparam int UPPER_HITS  = 60;
    localparam int MAX_POLLS   = 150;

    // bin reads and status polls after each frame, 4 cycles per access
    localparam int READOUT_CYCLES  = 4 * (`NUM_BINS + 20);
    localparam int WATCHDOG_CYCLES = FRAME1_LEN + FRAME2_LEN + FRAME3_LEN + FRAME4_LEN
                                     + 4 * READOUT_CYCLES + 1000;

    localparam logic [`WB_ADR_BITS-1:0] ADR_CTRL     = `WB_ADR_BITS'(REG_CTRL);
    localparam logic [`WB_ADR_BITS-1:0] ADR_FRAMELEN = `WB_ADR_BITS'(REG_FRAMELEN);
    localparam logic [`WB_ADR_BITS-1:0] ADR_WINSTART = `WB_ADR_BITS'(REG_WINSTART);
    localparam logic [`WB_ADR_BITS-1:0] ADR_STATUS   = `WB_ADR_BITS'(REG_STATUS);
    localparam logic [`WB_ADR_BITS-1:0] BIN_BASE     = 8'h80;
    localparam logic [`WB_ADR_BITS-1:0] UNUSED_ADR   = 8'h21;

    localparam int WIN_START = 1024;
    localparam int WIN_SPAN  = `NUM_BINS * (1 << `FINE_SHIFT);   // ticks covered in fine mode

    logic                    clk;
    logic                    res;
    logic                    hitValid;
    logic [`TS_BITS-1:0]     hitTime;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`WB_ADR_BITS-1:0] adr;
    logic [`WB_DAT_BITS-1:0] datWr;
    logic [`WB_DAT_BITS-1:0] datRd;
    logic                    ack;

    int          errorCount;
    int          checkCount;
    int          ackErrorCount;
    int          accessCount;
    logic [31:0] lfsrState;

    // reference model state
    bit ctrlEnable;
    bit ctrlFine;
    int winStartModel;
    int expFrameNum;
    int droppedHits;
    int expHist [`NUM_BINS];
    int prevHist [`NUM_BINS];   // fine frame, same bank as the lazy clear frame

    clockGen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10), .DRIVE_DELAY(DRIVE_DELAY)) clocks (
        .clk(clk),
        .res(res)
    );

    histTop UUT (
        .clk(clk), .res(res), .hitValid(hitValid), .hitTime(hitTime),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWr(datWr), .datRd(datRd), .ack(ack)
    );

    ackOnTime: assert property (@(posedge clk) disable iff (!res)
            ($past(cyc && stb, 2) && !$past(cyc && stb, 3)) |-> ack)
        else begin
            errorCount++;
            ackErrorCount++;
            $display("Fail at %0t ns: no ack two cycles after a request", $time);
        end

    ackOnlyOnTime: assert property (@(posedge clk) disable iff (!res)
            ack |-> ($past(cyc && stb, 2) && !$past(cyc && stb, 3)))
        else begin
            errorCount++;
            ackErrorCount++;
            $display("Fail at %0t ns: ack not exactly two cycles after a request", $time);
        end

    ackLowInReset: assert property (@(posedge clk) !res |-> !ack)
        else begin
            errorCount++;
            ackErrorCount++;
            $display("Fail at %0t ns: ack high during reset", $time);
        end

    function automatic logic lfsrNextBit();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h8020_0003;
        end
        return outBit;
    endfunction

    function automatic int randomBits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsrNextBit());
        end
        return value;
    endfunction

    // mapping rule of the front end, returns 0 for a dropped hit
    function automatic bit mapHit(input int ts, input bit fine, output int bin);
        int offset;
        bin = 0;
        if (!fine) begin
            bin = ts / (1 << `COARSE_SHIFT);
            return 1'b1;
        end
        if (ts < winStartModel) begin
            return 1'b0;
        end
        offset = (ts - winStartModel) / (1 << `FINE_SHIFT);
        if (offset >= `NUM_BINS) begin
            return 1'b0;
        end
        bin = offset;
        return 1'b1;
    endfunction

    // below, beyond or inside the window
    function automatic int fineTimestamp();
        int kind;
        kind = randomBits(2);
        if (kind == 0) begin
            return WIN_START - 1 - randomBits(8);
        end
        if (kind == 1) begin
            return WIN_START + WIN_SPAN + randomBits(8);
        end
        return WIN_START + randomBits(8);
    endfunction

    task automatic checkValue(input string what, input int got, input int exp);
        checkCount++;
        assert (got == exp) else begin
            errorCount++;
            $display("Fail at %0t ns: %s read %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic wbAccess(input bit write, input logic [`WB_ADR_BITS-1:0] address,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waitCycles;
        waitCycles = 0;
        rdata      = '0;
        @(posedge clk);
        #DRIVE_DELAY;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = address;
        datWr = wdata;
        accessCount++;
        while (!ack && waitCycles < ACK_TIMEOUT) begin
            @(negedge clk);                      // ack and datRd settled here
            waitCycles++;
        end
        if (ack) begin
            rdata = datRd;
        end else begin
            errorCount++;
            $display("no ack for the access to address %h within %0d cycles", address,
                     ACK_TIMEOUT);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wbWrite(input logic [`WB_ADR_BITS-1:0] address, input logic [31:0] data);
        logic [31:0] unused;
        wbAccess(1'b1, address, data, unused);
    endtask

    task automatic wbRead(input logic [`WB_ADR_BITS-1:0] address, output logic [31:0] data);
        wbAccess(1'b0, address, '0, data);
    endtask

    task automatic setControl(input bit enable, input bit fine);
        wbWrite(ADR_CTRL, {30'b0, fine, enable});
        ctrlEnable = enable;
        ctrlFine   = fine;
    endtask

    task automatic driveHit(input int ts);
        int bin;
        @(posedge clk);
        #DRIVE_DELAY;
        hitValid = 1'b1;
        hitTime  = ts[`TS_BITS-1:0];
        if (ctrlEnable) begin
            if (mapHit(ts, ctrlFine, bin)) begin
                expHist[bin]++;
            end else begin
                droppedHits++;
            end
        end
    endtask

    task automatic stopHits();
        @(posedge clk);
        #DRIVE_DELAY;
        hitValid = 1'b0;
    endtask

    task automatic startFrame(input int frameLen, input bit fine);
        for (int b = 0; b < `NUM_BINS; b++) begin
            expHist[b] = 0;
        end
        droppedHits = 0;
        wbWrite(ADR_FRAMELEN, 32'(frameLen));
        setControl(1'b1, fine);
    endtask

    // poll status, check the frame count, then stop acquisition
    task automatic awaitFrame();
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = '0;
        while (!status[0] && polls < MAX_POLLS) begin
            wbRead(ADR_STATUS, status);
            polls++;
        end
        if (!status[0]) begin
            errorCount++;
            $display("frameReady did not rise within %0d status reads", MAX_POLLS);
        end
        expFrameNum++;
        checkValue("frameNum", int'(status[31:16]), expFrameNum);
        wbRead(ADR_STATUS, status);
        checkValue("frameReady after a status read", int'(status[0]), 0);
        setControl(1'b0, ctrlFine);
    endtask

    task automatic readFrame();
        logic [31:0] data;
        for (int b = 0; b < `NUM_BINS; b++) begin
            wbRead(BIN_BASE | `WB_ADR_BITS'(b), data);
            checkValue($sformatf("bin %0d", b), int'(data), expHist[b]);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int          errorsBefore;
        int          staleBins;
        logic [31:0] data;
        hitValid      = 1'b0;
        hitTime       = '0;
        cyc           = 1'b0;
        stb           = 1'b0;
        we            = 1'b0;
        adr           = '0;
        datWr         = '0;
        lfsrState     = 32'h80d9_44c8;
        errorCount    = 0;
        checkCount    = 0;
        ackErrorCount = 0;
        accessCount   = 0;
        ctrlEnable    = 1'b0;
        ctrlFine      = 1'b0;
        winStartModel = 0;
        expFrameNum   = 0;
        @(posedge res);
        repeat (2) @(posedge clk);

        errorsBefore = errorCount;
        wbWrite(ADR_FRAMELEN, 32'd1234);
        wbRead(ADR_FRAMELEN, data);
        checkValue("frame length", int'(data), 1234);
        wbWrite(ADR_FRAMELEN, 32'd0);            // taken as 1
        wbRead(ADR_FRAMELEN, data);
        checkValue("frame length after writing 0", int'(data), 1);
        wbWrite(ADR_WINSTART, 32'hffff_fabc);
        wbRead(ADR_WINSTART, data);
        checkValue("window start", int'(data), 'habc);
        wbWrite(ADR_CTRL, 32'h2);                // fine mode, still disabled
        wbRead(ADR_CTRL, data);
        checkValue("control", int'(data), 2);
        setControl(1'b0, 1'b0);
        wbWrite(ADR_STATUS, 32'hffff_ffff);      // read only
        wbRead(ADR_STATUS, data);
        checkValue("status after write", int'(data), 0);
        wbRead(UNUSED_ADR, data);
        checkValue("unused address", int'(data), 0);
        wbRead(BIN_BASE | 8'd7, data);
        checkValue("bin 7 after reset", int'(data), 0);
        reportTest("registers", errorsBefore);

        errorsBefore = errorCount;
        repeat (10) driveHit(randomBits(`TS_BITS));   // acquisition still off
        stopHits();
        startFrame(FRAME1_LEN, 1'b0);
        repeat (RANDOM_HITS) driveHit(randomBits(`TS_BITS));
        stopHits();
        awaitFrame();
        readFrame();
        reportTest("coarse random frame", errorsBefore);

        errorsBefore  = errorCount;
        winStartModel = WIN_START;
        wbWrite(ADR_WINSTART, 32'(WIN_START));
        startFrame(FRAME2_LEN, 1'b1);
        driveHit(WIN_START - 1);
        driveHit(WIN_START);
        driveHit(WIN_START + WIN_SPAN - 1);
        driveHit(WIN_START + WIN_SPAN);
        driveHit(0);
        driveHit((1 << `TS_BITS) - 1);
        repeat (RANDOM_HITS) driveHit(fineTimestamp());
        stopHits();
        awaitFrame();
        readFrame();
        prevHist = expHist;
        reportTest($sformatf("fine window frame, %0d hits dropped", droppedHits), errorsBefore);

        errorsBefore = errorCount;
        startFrame(FRAME3_LEN, 1'b0);
        repeat (6) driveHit(5 * 64 + 3);
        driveHit(17 * 64);
        repeat (9) driveHit(40 * 64 + 63);
        repeat (4) begin
            driveHit(50 * 64);                   // alternating bins
            driveHit(51 * 64 + 10);
        end
        repeat (3) driveHit(63 * 64);
        stopHits();
        awaitFrame();
        readFrame();
        reportTest("runs of equal timestamps", errorsBefore);

        errorsBefore = errorCount;
        startFrame(FRAME4_LEN, 1'b0);
        repeat (UPPER_HITS) driveHit((1 << (`TS_BITS - 1)) + randomBits(`TS_BITS - 1));
        stopHits();
        awaitFrame();
        readFrame();
        staleBins = 0;
        for (int b = 0; b < `NUM_BINS; b++) begin
            if (prevHist[b] > 0 && expHist[b] == 0) begin
                staleBins++;
            end
        end
        if (staleBins == 0) begin
            errorCount++;
            $display("no bin of the earlier frame in this bank was left unhit");
        end
        reportTest($sformatf("lazy clear frame, %0d stale bins", staleBins), errorsBefore);

        $display("ack timing: %0d accesses, %0d errors", accessCount, ackErrorCount);
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
